//--- proc_pkg.sv
/*
 * Shared definitions for the 16-bit single-cycle processor: word widths,
 * opcode table, ALU and write-back selects, and the instruction word views
 */
package proc_pkg;

   localparam int data_w     = 16;
   localparam int reg_addr_w = 3;
   localparam int mem_addr_w = 6;
   localparam int num_regs   = 1 << reg_addr_w;
   localparam int mem_depth  = 1 << mem_addr_w;

   // Opcode table, anything else traps as illegal
   localparam logic [4:0] op_halt = 5'b00000;
   localparam logic [4:0] op_nop  = 5'b00001;
   localparam logic [4:0] op_addi = 5'b01000;
   localparam logic [4:0] op_beqz = 5'b01100;
   localparam logic [4:0] op_bnez = 5'b01101;
   localparam logic [4:0] op_st   = 5'b10000;
   localparam logic [4:0] op_ld   = 5'b10001;
   localparam logic [4:0] op_lbi  = 5'b11000;
   localparam logic [4:0] op_alu  = 5'b11011;

   // Function field of register-format instructions
   localparam logic [1:0] fn_add = 2'd0;
   localparam logic [1:0] fn_sub = 2'd1;
   localparam logic [1:0] fn_and = 2'd2;
   localparam logic [1:0] fn_xor = 2'd3;

   localparam logic [2:0] alu_add    = 3'd0;
   localparam logic [2:0] alu_sub    = 3'd1;
   localparam logic [2:0] alu_and    = 3'd2;
   localparam logic [2:0] alu_xor    = 3'd3;
   localparam logic [2:0] alu_pass_b = 3'd4;

   localparam logic [1:0] wb_alu = 2'd0;
   localparam logic [1:0] wb_mem = 2'd1;
   localparam logic [1:0] wb_imm = 2'd2;

   // Fetch controller states
   localparam logic [1:0] st_load   = 2'd0;
   localparam logic [1:0] st_run    = 2'd1;
   localparam logic [1:0] st_halted = 2'd2;

   typedef struct packed {
      logic [4:0] opcode;
      logic [2:0] rs;
      logic [2:0] rt;
      logic [2:0] rd;
      logic [1:0] func;
   } r_fmt_t;

   // imm8 of LBI and branches is the low byte, spanning rd and imm5
   typedef struct packed {
      logic [4:0] opcode;
      logic [2:0] rs;
      logic [2:0] rd;
      logic [4:0] imm5;
   } i_fmt_t;

   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
   } instr_t;

endpackage

//--- ctrl_if.sv
/*
 * Decoded control bundle, driven by the control unit and read by
 * fetch, execute, the register file and the memory stage
 */
`timescale 1ns/1ps

interface ctrl_if;
   import proc_pkg::*;

   logic [2:0]        alu_op;
   logic              use_imm;
   logic [data_w-1:0] imm;
   logic              wr_en;
   logic [reg_addr_w-1:0] wr_reg;
   logic [1:0]        wb_sel;
   logic              mem_en;
   logic              mem_wr;
   logic              br_instr;
   logic              br_on_zero;
   logic              halt;

   modport ctrl (output alu_op, use_imm, imm, wr_en, wr_reg, wb_sel,
                 mem_en, mem_wr, br_instr, br_on_zero, halt);
   modport exec (input alu_op, use_imm, imm, br_instr, br_on_zero);
   modport mem  (input mem_en, mem_wr, wb_sel, imm);
   modport rf   (input wr_en, wr_reg);
   modport fetch (input halt);

endinterface

//--- fetch.sv
/*
 * Fetch stage: load/run/halted controller, program load into the
 * instruction memory, and the PC that steps or branches each cycle
 */
`timescale 1ns/1ps

module fetch (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          prog_valid,
   output logic                          prog_ready,
   input  logic [proc_pkg::data_w-1:0]   prog_data,
   input  logic                          prog_last,
   input  logic                          take_br,
   input  logic [proc_pkg::mem_addr_w-1:0] br_target,
   input  logic                          illegal,
   output proc_pkg::instr_t              instr,
   output logic [proc_pkg::mem_addr_w-1:0] pc,
   output logic                          running,
   output logic                          halted,
   output logic                          err,
   ctrl_if.fetch                         ctrl
);
   import proc_pkg::*;

   logic [1:0]            state;
   logic [mem_addr_w-1:0] load_addr;
   logic [data_w-1:0]     imem [mem_depth];

   assign prog_ready = (state == st_load);
   assign running    = (state == st_run);
   assign halted     = (state == st_halted);

   assign instr = imem[pc];

   // Program words land at consecutive addresses from 0
   always_ff @(posedge clk) begin
      if (prog_ready && prog_valid) begin
         imem[load_addr] <= prog_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state     <= st_load;
         load_addr <= '0;
         pc        <= '0;
         err       <= 1'b0;
      end else begin
         case (state)
            st_load: begin
               if (prog_valid) begin
                  load_addr <= load_addr + 1'b1;
                  if (prog_last) begin
                     state <= st_run;
                     pc    <= '0;
                  end
               end
            end
            st_run: begin
               // HALT or a trap freezes the PC
               if (ctrl.halt) begin
                  state <= st_halted;
                  err   <= illegal;
               end else begin
                  pc <= take_br ? br_target : pc + 1'b1;
               end
            end
            st_halted: ;
            default: state <= st_halted;
         endcase
      end
   end

endmodule

//--- decode.sv
/*
 * Control unit: decodes the instruction word in its register or
 * immediate view, sign-extends immediates and traps illegal opcodes
 */
`timescale 1ns/1ps

module decode (
   input  proc_pkg::instr_t                instr,
   input  logic                            running,
   output logic                            illegal,
   ctrl_if.ctrl                            ctrl,
   output logic [proc_pkg::reg_addr_w-1:0] rs_reg,
   output logic [proc_pkg::reg_addr_w-1:0] rt_reg
);
   import proc_pkg::*;

   logic [data_w-1:0] imm5_sext;
   logic [data_w-1:0] imm8_sext;
   logic [7:0]        imm8;

   assign imm8      = {instr.i.rd, instr.i.imm5};
   assign imm5_sext = {{(data_w-5){instr.i.imm5[4]}}, instr.i.imm5};
   assign imm8_sext = {{(data_w-8){imm8[7]}}, imm8};

   // Store data register is the i view rd, which sits in the rt bits
   assign rs_reg = instr.r.rs;
   assign rt_reg = instr.r.rt;

   always_comb begin
      ctrl.alu_op     = alu_add;
      ctrl.use_imm    = 1'b0;
      ctrl.imm        = '0;
      ctrl.wr_en      = 1'b0;
      ctrl.wr_reg     = '0;
      ctrl.wb_sel     = wb_alu;
      ctrl.mem_en     = 1'b0;
      ctrl.mem_wr     = 1'b0;
      ctrl.br_instr   = 1'b0;
      ctrl.br_on_zero = 1'b0;
      ctrl.halt       = 1'b0;
      illegal         = 1'b0;
      if (running) begin
         case (instr.r.opcode)
            op_nop: ;
            op_halt: ctrl.halt = 1'b1;
            op_alu: begin
               ctrl.wr_en  = 1'b1;
               ctrl.wr_reg = instr.r.rd;
               case (instr.r.func)
                  fn_add:  ctrl.alu_op = alu_add;
                  fn_sub:  ctrl.alu_op = alu_sub;
                  fn_and:  ctrl.alu_op = alu_and;
                  default: ctrl.alu_op = alu_xor;
               endcase
            end
            op_addi: begin
               ctrl.use_imm = 1'b1;
               ctrl.imm     = imm5_sext;
               ctrl.wr_en   = 1'b1;
               ctrl.wr_reg  = instr.i.rd;
            end
            op_lbi: begin
               ctrl.use_imm = 1'b1;
               ctrl.imm     = imm8_sext;
               ctrl.alu_op  = alu_pass_b;
               ctrl.wr_en   = 1'b1;
               ctrl.wr_reg  = instr.i.rs;
               ctrl.wb_sel  = wb_imm;
            end
            op_ld: begin
               ctrl.use_imm = 1'b1;
               ctrl.imm     = imm5_sext;
               ctrl.mem_en  = 1'b1;
               ctrl.wr_en   = 1'b1;
               ctrl.wr_reg  = instr.i.rd;
               ctrl.wb_sel  = wb_mem;
            end
            op_st: begin
               ctrl.use_imm = 1'b1;
               ctrl.imm     = imm5_sext;
               ctrl.mem_en  = 1'b1;
               ctrl.mem_wr  = 1'b1;
            end
            op_beqz, op_bnez: begin
               ctrl.br_instr   = 1'b1;
               ctrl.br_on_zero = (instr.r.opcode == op_beqz);
               ctrl.imm        = imm8_sext;
            end
            default: begin
               illegal   = 1'b1;
               ctrl.halt = 1'b1;
            end
         endcase
      end
   end

endmodule

//--- regfile.sv
/*
 * Register file: eight 16-bit registers, two combinational read
 * ports and one write port that updates on the clock edge
 */
`timescale 1ns/1ps

module regfile (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic [proc_pkg::reg_addr_w-1:0] rs_reg,
   input  logic [proc_pkg::reg_addr_w-1:0] rt_reg,
   output logic [proc_pkg::data_w-1:0]     rd_data_1,
   output logic [proc_pkg::data_w-1:0]     rd_data_2,
   input  logic [proc_pkg::data_w-1:0]     wr_data,
   ctrl_if.rf                              ctrl
);
   import proc_pkg::*;

   logic [data_w-1:0] regs [num_regs];

   // No bypass, a same-cycle read sees the old value
   assign rd_data_1 = regs[rs_reg];
   assign rd_data_2 = regs[rt_reg];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < num_regs; i++) begin
            regs[i] <= '0;
         end
      end else if (ctrl.wr_en) begin
         regs[ctrl.wr_reg] <= wr_data;
      end
   end

endmodule

//--- execute.sv
/*
 * Execute stage: operand select, ALU, zero test for the conditional
 * branches and the PC-relative branch target
 */
`timescale 1ns/1ps

module execute (
   input  logic [proc_pkg::data_w-1:0]     rd_data_1,
   input  logic [proc_pkg::data_w-1:0]     rd_data_2,
   input  logic [proc_pkg::mem_addr_w-1:0] pc,
   ctrl_if.exec                            ctrl,
   output logic [proc_pkg::data_w-1:0]     alu_out,
   output logic                            take_br,
   output logic [proc_pkg::mem_addr_w-1:0] br_target
);
   import proc_pkg::*;

   logic [data_w-1:0]     oprnd_b;
   logic [mem_addr_w-1:0] pc_inc;
   logic                  rs_zero;

   assign oprnd_b = ctrl.use_imm ? ctrl.imm : rd_data_2;

   always_comb begin
      case (ctrl.alu_op)
         alu_add:    alu_out = rd_data_1 + oprnd_b;
         alu_sub:    alu_out = rd_data_1 - oprnd_b;
         alu_and:    alu_out = rd_data_1 & oprnd_b;
         alu_xor:    alu_out = rd_data_1 ^ oprnd_b;
         alu_pass_b: alu_out = oprnd_b;
         default:    alu_out = '0;
      endcase
   end

   // Branch tests rs, BEQZ on zero and BNEZ otherwise
   assign rs_zero = (rd_data_1 == '0);
   assign take_br = ctrl.br_instr && (ctrl.br_on_zero ? rs_zero : !rs_zero);

   // Offset is relative to the next PC, wraps within the 64-word space
   assign pc_inc    = pc + 1'b1;
   assign br_target = pc_inc + ctrl.imm[mem_addr_w-1:0];

endmodule

//--- mem_wb.sv
/*
 * Memory and write-back stage: 64-word data memory addressed by the
 * ALU result, plus the select of the data written to the register file
 */
`timescale 1ns/1ps

module mem_wb (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic [proc_pkg::data_w-1:0] alu_out,
   input  logic [proc_pkg::data_w-1:0] st_data,
   ctrl_if.mem                         ctrl,
   output logic [proc_pkg::data_w-1:0] wr_data
);
   import proc_pkg::*;

   logic [data_w-1:0]     dmem [mem_depth];
   logic [mem_addr_w-1:0] addr;
   logic [data_w-1:0]     mem_out;

   assign addr    = alu_out[mem_addr_w-1:0];
   assign mem_out = ctrl.mem_en ? dmem[addr] : '0;

   // Cleared so a load from an unwritten word returns 0
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < mem_depth; i++) begin
            dmem[i] <= '0;
         end
      end else if (ctrl.mem_en && ctrl.mem_wr) begin
         dmem[addr] <= st_data;
      end
   end

   always_comb begin
      case (ctrl.wb_sel)
         wb_mem:  wr_data = mem_out;
         wb_imm:  wr_data = ctrl.imm;
         default: wr_data = alu_out;
      endcase
   end

endmodule

//--- proc.sv
/*
 * Single-cycle 16-bit processor top level: fetch, decode, register
 * file, execute and memory/write-back, with program load and trace ports
 */
`timescale 1ns/1ps

module proc (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            prog_valid,
   output logic                            prog_ready,
   input  logic [proc_pkg::data_w-1:0]     prog_data,
   input  logic                            prog_last,
   output logic                            retire_valid,
   output logic [proc_pkg::mem_addr_w-1:0] retire_pc,
   output logic                            retire_wr_en,
   output logic [proc_pkg::reg_addr_w-1:0] retire_wr_reg,
   output logic [proc_pkg::data_w-1:0]     retire_wr_data,
   output logic                            halted,
   output logic                            err
);
   import proc_pkg::*;

   instr_t                instr;
   logic [mem_addr_w-1:0] pc;
   logic [mem_addr_w-1:0] br_target;
   logic                  take_br;
   logic                  running;
   logic                  illegal;
   logic [reg_addr_w-1:0] rs_reg;
   logic [reg_addr_w-1:0] rt_reg;
   logic [data_w-1:0]     rd_data_1;
   logic [data_w-1:0]     rd_data_2;
   logic [data_w-1:0]     alu_out;
   logic [data_w-1:0]     wr_data;

   ctrl_if ctrl ();

   fetch fetch0 (.clk(clk), .rst_n(rst_n), .prog_valid(prog_valid),
                 .prog_ready(prog_ready), .prog_data(prog_data),
                 .prog_last(prog_last), .take_br(take_br), .br_target(br_target),
                 .illegal(illegal), .instr(instr), .pc(pc), .running(running),
                 .halted(halted), .err(err), .ctrl(ctrl.fetch));

   decode decode0 (.instr(instr), .running(running), .illegal(illegal),
                   .ctrl(ctrl.ctrl), .rs_reg(rs_reg), .rt_reg(rt_reg));

   regfile regfile0 (.clk(clk), .rst_n(rst_n), .rs_reg(rs_reg), .rt_reg(rt_reg),
                     .rd_data_1(rd_data_1), .rd_data_2(rd_data_2),
                     .wr_data(wr_data), .ctrl(ctrl.rf));

   execute execute0 (.rd_data_1(rd_data_1), .rd_data_2(rd_data_2), .pc(pc),
                     .ctrl(ctrl.exec), .alu_out(alu_out), .take_br(take_br),
                     .br_target(br_target));

   mem_wb mem_wb0 (.clk(clk), .rst_n(rst_n), .alu_out(alu_out),
                   .st_data(rd_data_2), .ctrl(ctrl.mem), .wr_data(wr_data));

   // One instruction retires in every running cycle
   assign retire_valid   = running;
   assign retire_pc      = pc;
   assign retire_wr_en   = ctrl.wr_en;
   assign retire_wr_reg  = ctrl.wr_reg;
   assign retire_wr_data = wr_data;

endmodule

//--- tb_proc.sv
/*
 * Testbench for the single-cycle processor: loads each program through the
 * handshake and follows every retire against an ISA reference model
 */
`timescale 1ns/1ps

module tb_proc;
   import proc_pkg::*;

   logic        clk, rst_n, prog_valid, prog_ready, prog_last;
   logic [15:0] prog_data;
   logic        retire_valid, retire_wr_en, halted, err;
   logic [5:0]  retire_pc;
   logic [2:0]  retire_wr_reg;
   logic [15:0] retire_wr_data;

   // Reference model state and the program image
   logic [15:0] prog [64];
   logic [15:0] m_regs [8];
   logic [15:0] m_mem [64];
   logic [5:0]  m_pc;
   logic        m_halted, m_err;
   int          prog_len, errors, checks;
   logic        stuck;
   int unsigned seed;

   proc uut (.clk(clk), .rst_n(rst_n), .prog_valid(prog_valid), .prog_ready(prog_ready),
             .prog_data(prog_data), .prog_last(prog_last), .retire_valid(retire_valid),
             .retire_pc(retire_pc), .retire_wr_en(retire_wr_en),
             .retire_wr_reg(retire_wr_reg), .retire_wr_data(retire_wr_data),
             .halted(halted), .err(err));

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   assert property (@(posedge clk) disable iff (!rst_n) halted |-> !retire_valid && !prog_ready)
      else begin
         errors++;
         $display("retire or load ready seen while halted");
      end

   function automatic logic [15:0] lcg_next();
      seed = seed * 32'd1103515245 + 32'd12345;
      return {1'b0, seed[30:16]};
   endfunction

   function automatic logic [15:0] enc_alu(logic [1:0] fn, logic [2:0] rs, rt, rd);
      return {op_alu, rs, rt, rd, fn};
   endfunction

   function automatic logic [15:0] enc_imm(logic [4:0] op, logic [2:0] rs, rd, logic [4:0] imm5);
      return {op, rs, rd, imm5};
   endfunction

   function automatic logic [15:0] enc_byte(logic [4:0] op, logic [2:0] rs, logic [7:0] imm8);
      return {op, rs, imm8};
   endfunction

   task automatic add_word(logic [15:0] w);
      prog[prog_len] = w;
      prog_len++;
   endtask

   task automatic check_val(string test, string field, logic [15:0] exp, logic [15:0] act);
      checks++;
      assert (act === exp) else begin
         errors++;
         $display("mismatch %s %s expected %0h actual %0h", test, field, exp, act);
      end
   endtask

   // One ISA step on the model, returns the expected register write
   task automatic model_step(output logic en, output logic [2:0] rd, output logic [15:0] data);
      logic [15:0] w, a, sum, s5, s8;
      logic [5:0]  addr, pc_next;
      w = prog[m_pc];
      a = m_regs[w[10:8]];
      s5 = {{11{w[4]}}, w[4:0]};
      s8 = {{8{w[7]}}, w[7:0]};
      sum = a + s5;
      addr = sum[5:0];
      pc_next = m_pc + 6'd1;
      en = 1'b0;
      rd = '0;
      data = '0;
      case (w[15:11])
         op_nop: ;
         op_halt: m_halted = 1'b1;
         op_alu: begin
            en = 1'b1;
            rd = w[4:2];
            case (w[1:0])
               2'd0: data = a + m_regs[w[7:5]];
               2'd1: data = a - m_regs[w[7:5]];
               2'd2: data = a & m_regs[w[7:5]];
               default: data = a ^ m_regs[w[7:5]];
            endcase
         end
         op_addi: {en, rd, data} = {1'b1, w[7:5], sum};
         op_lbi:  {en, rd, data} = {1'b1, w[10:8], s8};
         op_ld:   {en, rd, data} = {1'b1, w[7:5], m_mem[addr]};
         op_st:   m_mem[addr] = m_regs[w[7:5]];
         op_beqz: if (a == 0) pc_next = m_pc + 6'd1 + s8[5:0];
         op_bnez: if (a != 0) pc_next = m_pc + 6'd1 + s8[5:0];
         default: {m_halted, m_err} = 2'b11;
      endcase
      if (en) m_regs[rd] = data;
      if (!m_halted) m_pc = pc_next;
   endtask

   task automatic start_test(string test);
      @(negedge clk);
      rst_n = 1'b0;
      repeat (3) @(negedge clk);
      rst_n = 1'b1;
      foreach (m_regs[i]) m_regs[i] = '0;
      foreach (m_mem[i]) m_mem[i] = '0;
      {m_pc, m_halted, m_err} = '0;
      check_val(test, "prog_ready after reset", 1, prog_ready);
      check_val(test, "halted/err after reset", 0, {halted, err});
   endtask

   task automatic load_program(string test);
      int t;
      for (int k = 0; k < prog_len && !stuck; k++) begin
         t = 0;
         while (!prog_ready && t < 20) begin
            @(negedge clk);
            t++;
         end
         if (!prog_ready) begin
            errors++;
            stuck = 1'b1;
            $display("%s: prog_ready did not rise within 20 cycles", test);
         end else begin
            check_val(test, "retire_valid during load", 0, retire_valid);
            prog_valid = 1'b1;
            prog_data = prog[k];
            prog_last = (k == prog_len - 1);
            @(negedge clk);
         end
      end
      prog_valid = 1'b0;
      prog_last = 1'b0;
      check_val(test, "prog_ready after last word", 0, prog_ready);
   endtask

   task automatic run_program(string test);
      int          cycles;
      logic        en;
      logic [2:0]  rd;
      logic [15:0] data;
      cycles = 0;
      while (!m_halted && cycles < 200) begin
         check_val(test, "retire_valid", 1, retire_valid);
         check_val(test, "retire_pc", m_pc, retire_pc);
         model_step(en, rd, data);
         check_val(test, "retire_wr_en", en, retire_wr_en);
         if (en) begin
            check_val(test, "retire_wr_reg", rd, retire_wr_reg);
            check_val(test, "retire_wr_data", data, retire_wr_data);
         end
         @(negedge clk);
         cycles++;
      end
      if (!m_halted) begin
         errors++;
         stuck = 1'b1;
         $display("%s: program did not halt within 200 cycles", test);
      end
      repeat (2) begin
         check_val(test, "retire_valid after halt", 0, retire_valid);
         check_val(test, "halted", 1, halted);
         check_val(test, "err", m_err, err);
         @(negedge clk);
      end
   endtask

   task automatic run_test(string test);
      int e0;
      if (!stuck) begin
         e0 = errors;
         start_test(test);
         load_program(test);
         if (!stuck) run_program(test);
         $display("test %s %s with %0d errors", test, (errors == e0) ? "passed" : "failed",
                  errors - e0);
      end
      prog_len = 0;
   endtask

   initial begin
      logic [15:0] rnd;
      {rst_n, prog_valid, prog_last, prog_data} = '0;
      {errors, checks, prog_len, stuck} = '0;
      seed = 69350;

      add_word(enc_byte(op_lbi, 3'd1, 8'd5));
      add_word(enc_imm(op_addi, 3'd1, 3'd2, 5'd3));
      add_word(16'h0000);
      run_test("load_handshake");

      for (int r = 1; r <= 4; r++) begin
         rnd = lcg_next();
         add_word(enc_byte(op_lbi, 3'(r), rnd[7:0]));
      end
      add_word(enc_alu(fn_add, 3'd1, 3'd2, 3'd5));
      add_word(enc_alu(fn_sub, 3'd3, 3'd1, 3'd6));
      add_word(enc_alu(fn_and, 3'd5, 3'd4, 3'd7));
      add_word(enc_alu(fn_xor, 3'd6, 3'd7, 3'd0));
      add_word(enc_alu(fn_add, 3'd0, 3'd0, 3'd1));
      add_word(16'h0000);
      run_test("alu");

      rnd = lcg_next();
      add_word(enc_byte(op_lbi, 3'd1, 8'hFD));
      add_word(enc_imm(op_addi, 3'd1, 3'd2, 5'h10));
      add_word(enc_imm(op_addi, 3'd0, 3'd3, 5'h1F));
      add_word(enc_byte(op_lbi, 3'd4, 8'h80));
      add_word(enc_imm(op_addi, 3'd4, 3'd5, rnd[4:0]));
      add_word(16'h0000);
      run_test("immediates");

      // Stores around address 10, one load from a word never written
      rnd = lcg_next();
      add_word(enc_byte(op_lbi, 3'd1, 8'd10));
      add_word(enc_byte(op_lbi, 3'd2, rnd[7:0]));
      add_word(enc_imm(op_st, 3'd1, 3'd2, 5'd0));
      add_word(enc_imm(op_st, 3'd1, 3'd1, 5'd1));
      add_word(enc_imm(op_st, 3'd1, 3'd2, 5'h1E));
      add_word(enc_imm(op_ld, 3'd1, 3'd3, 5'd0));
      add_word(enc_imm(op_ld, 3'd1, 3'd4, 5'd1));
      add_word(enc_imm(op_ld, 3'd1, 3'd5, 5'd5));
      add_word(enc_imm(op_ld, 3'd1, 3'd6, 5'h1E));
      add_word(16'h0000);
      run_test("memory");

      add_word(enc_byte(op_lbi, 3'd1, 8'd0));
      add_word(enc_byte(op_lbi, 3'd2, 8'd3));
      add_word(enc_byte(op_beqz, 3'd1, 8'd2));
      add_word(enc_byte(op_lbi, 3'd7, 8'd1));
      add_word(16'h0000);
      add_word(enc_imm(op_addi, 3'd2, 3'd2, 5'h1F));
      add_word(enc_byte(op_bnez, 3'd2, 8'hFE));
      add_word(enc_byte(op_bnez, 3'd1, 8'd5));
      add_word(enc_byte(op_lbi, 3'd3, 8'd9));
      add_word(enc_byte(op_beqz, 3'd3, 8'hF7));
      add_word(enc_byte(op_beqz, 3'd1, 8'd1));
      add_word(enc_byte(op_lbi, 3'd7, 8'd2));
      add_word(16'h0000);
      run_test("branches");

      add_word({op_nop, 11'd0});
      add_word(enc_byte(op_lbi, 3'd1, 8'd1));
      add_word(16'h0000);
      run_test("halt");

      add_word(enc_byte(op_lbi, 3'd1, 8'd7));
      add_word(16'hF800);
      add_word(enc_byte(op_lbi, 3'd2, 8'd1));
      run_test("illegal");

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

//--- flist.f
proc_pkg.sv
ctrl_if.sv
fetch.sv
decode.sv
regfile.sv
execute.sv
mem_wb.sv
proc.sv
tb_proc.sv

//--- Bender.yml
package:
  name: proc

sources:
  - proc_pkg.sv
  - ctrl_if.sv
  - fetch.sv
  - decode.sv
  - regfile.sv
  - execute.sv
  - mem_wb.sv
  - proc.sv
  - target: test
    files:
      - tb_proc.sv
